/* flist.f */
+incdir+include
verilog/posMapPkg.sv
verilog/syncRam.sv
verilog/leafRng.sv
verilog/leafCache.sv
verilog/posMapPlb.sv
tests/posMapPlb_assertions.sv
tests/posMapPlbTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module posMapPlbTb -f flist.f -o simv \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

/* tests/posMapPlbTb.sv */
`default_nettype none

`include "posMap_cfg.svh"

module posMapPlbTb;

    import posMapPkg::*;

    localparam int onChipEntries = 1 << `POSMAP_LOG_ONCHIP;
    localparam int numLines      = 1 << `POSMAP_LOG_LINES;
    localparam int offW          = `POSMAP_LOG_LEAVES;
    localparam int tagLo         = `POSMAP_LOG_LEAVES + `POSMAP_LOG_LINES;

    typedef struct {
        cacheCmdT  cmd;
        addrT      addr;
        leafBlockT fill;
        logic      expHit;
        logic      expEvict;
    } rowT;

    logic      Clock;
    logic      rst;
    logic      cmdReady;
    logic      cmdValid;
    cacheCmdT  cmd;
    addrT      addr;
    leafBlockT fillData;
    logic      outReady;
    logic      valid;
    logic      hit;
    leafT      oldLeaf;
    leafT      newLeaf;
    logic      evict;
    addrT      evictAddr;
    leafBlockT evictData;

    rowT        rows[$];
    int         errorCount;
    int         failedTests;
    logic [7:0] noiseState;   // Back-pressure source

    // Reference model of the map, the cache lines and the leaf generator
    leafT                     refOnChip [0:onChipEntries-1];
    logic                     refOnChipSet [0:onChipEntries-1];
    logic                     refLineValid [0:numLines-1];
    logic [`POSMAP_TAG_W-1:0] refLineTag [0:numLines-1];
    leafBlockT                refLineData [0:numLines-1];
    logic [15:0]              refRng;
    leafT                     expOld;
    leafT                     expNew;
    addrT                     expEvictAddr;
    leafBlockT                expEvictData;

    posMapPlb u_dut (
        .Clock     (Clock),
        .rst       (rst),
        .cmdReady  (cmdReady),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .addr      (addr),
        .fillData  (fillData),
        .outReady  (outReady),
        .valid     (valid),
        .hit       (hit),
        .oldLeaf   (oldLeaf),
        .newLeaf   (newLeaf),
        .evict     (evict),
        .evictAddr (evictAddr),
        .evictData (evictData)
    );

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [7:0] stepNoise(input logic [7:0] s);
        return (s >> 1) ^ (s[0] ? 8'hB8 : 8'h00);
    endfunction

    // Model of one leaf generator step
    function automatic logic [15:0] stepLeafModel(input logic [15:0] s);
        logic [15:0] shifted;
        shifted = s >> 1;
        if (s[0]) shifted = shifted ^ `POSMAP_RNG_TAPS;
        return shifted;
    endfunction

    function automatic leafBlockT makeBlock(input leafT s0, input leafT s1,
                                            input leafT s2, input leafT s3);
        leafBlockT b;
        b[0] = s0;
        b[1] = s1;
        b[2] = s2;
        b[3] = s3;
        return b;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic addRow(input cacheCmdT c, input addrT a, input leafBlockT f,
                          input logic h, input logic e);
        rowT r;
        r.cmd      = c;
        r.addr     = a;
        r.fill     = f;
        r.expHit   = h;
        r.expEvict = e;
        rows.push_back(r);
    endtask

    // Advance to the next falling edge and draw one back-pressure bit
    task automatic nextCycle();
        @(negedge Clock);
        outReady   = noiseState[0];
        noiseState = stepNoise(noiseState);
    endtask

    task automatic predict(input rowT r);
        logic [`POSMAP_TAG_W-1:0]     tag;
        logic [`POSMAP_LOG_LINES-1:0] idx;
        logic [offW-1:0]              off;
        logic [`POSMAP_LOG_ONCHIP-1:0] slot;
        logic                         lineHit;
        tag  = r.addr[`POSMAP_ADDR_W-1:tagLo];
        idx  = r.addr[tagLo-1:offW];
        off  = r.addr[offW-1:0];
        slot = r.addr[`POSMAP_LOG_ONCHIP-1:0];
        expEvictAddr = '0;
        expEvictData = '0;
        if (r.addr >= `POSMAP_ONCHIP_START) begin
            expOld = refOnChipSet[slot] ? refOnChip[slot] : '0;
            expNew = refRng[`POSMAP_LEAF_W-1:0];
            if (r.cmd == CmdUpdate) begin
                refOnChip[slot]    = expNew;
                refOnChipSet[slot] = 1'b1;
                refRng             = stepLeafModel(refRng);
            end
        end else if (r.cmd == CmdRefill) begin
            expOld = '0;
            expNew = r.fill[off];   // Own slot of the incoming block
            if (refLineValid[idx] && refLineTag[idx] != tag) begin
                expEvictAddr = {refLineTag[idx], idx, {offW{1'b0}}};
                expEvictData = refLineData[idx];
            end
            refLineValid[idx] = 1'b1;
            refLineTag[idx]   = tag;
            refLineData[idx]  = r.fill;
        end else begin
            lineHit = refLineValid[idx] && (refLineTag[idx] == tag);
            expOld  = lineHit ? refLineData[idx][off] : '0;
            expNew  = refRng[`POSMAP_LEAF_W-1:0];
            if (r.cmd == CmdUpdate && lineHit) begin
                refLineData[idx][off] = expNew;
                refRng                = stepLeafModel(refRng);
            end
        end
    endtask

    task automatic applyRow(input rowT r);
        cmdValid = 1'b1;
        cmd      = r.cmd;
        addr     = r.addr;
        fillData = r.fill;
        while (!cmdReady) nextCycle();
        nextCycle();   // Acceptance edge has passed
        cmdValid = 1'b0;
        predict(r);
        while (!(valid && outReady)) nextCycle();
        checkValue("hit", 64'(hit), 64'(r.expHit));
        checkValue("evict", 64'(evict), 64'(r.expEvict));
        checkValue("oldLeaf", 64'(oldLeaf), 64'(expOld));
        checkValue("newLeaf", 64'(newLeaf), 64'(expNew));
        checkValue("evictAddr", 64'(evictAddr), 64'(expEvictAddr));
        checkValue("evictData", 64'(evictData), 64'(expEvictData));
        nextCycle();
    endtask

    // ======================================================================
    // Command table
    // ======================================================================
    task automatic buildTable();
        addRow(CmdUpdate, 12'hF12, '0, 1'b1, 1'b0);   // Unset on-chip entry
        addRow(CmdRead,   12'hF12, '0, 1'b1, 1'b0);
        addRow(CmdUpdate, 12'hF34, '0, 1'b1, 1'b0);
        addRow(CmdUpdate, 12'h104, '0, 1'b0, 1'b0);   // Empty line
        addRow(CmdRead,   12'h104, '0, 1'b0, 1'b0);
        addRow(CmdRefill, 12'h104, makeBlock(10'h011, 10'h022, 10'h033, 10'h044), 1'b0, 1'b0);
        addRow(CmdRead,   12'h104, '0, 1'b1, 1'b0);
        addRow(CmdRead,   12'h105, '0, 1'b1, 1'b0);
        addRow(CmdRead,   12'h106, '0, 1'b1, 1'b0);
        addRow(CmdRead,   12'h107, '0, 1'b1, 1'b0);
        addRow(CmdUpdate, 12'h105, '0, 1'b1, 1'b0);
        addRow(CmdRead,   12'h105, '0, 1'b1, 1'b0);
        addRow(CmdRead,   12'h106, '0, 1'b1, 1'b0);
        // Same line with another tag
        addRow(CmdRefill, 12'h4C4, makeBlock(10'h3A1, 10'h3A2, 10'h3A3, 10'h3A4), 1'b0, 1'b1);
        addRow(CmdRead,   12'h105, '0, 1'b0, 1'b0);
        addRow(CmdRead,   12'h4C7, '0, 1'b1, 1'b0);
        addRow(CmdUpdate, 12'h4C6, '0, 1'b1, 1'b0);
        addRow(CmdRefill, 12'h208, makeBlock(10'h101, 10'h102, 10'h103, 10'h104), 1'b0, 1'b0);
        addRow(CmdUpdate, 12'h20B, '0, 1'b1, 1'b0);
        addRow(CmdRefill, 12'h104, makeBlock(10'h0AA, 10'h0BB, 10'h0CC, 10'h0DD), 1'b0, 1'b1);
        addRow(CmdRead,   12'hF34, '0, 1'b1, 1'b0);
        addRow(CmdUpdate, 12'hF12, '0, 1'b1, 1'b0);
        addRow(CmdRead,   12'h105, '0, 1'b1, 1'b0);
        addRow(CmdUpdate, 12'h3F0, '0, 1'b0, 1'b0);
        addRow(CmdRead,   12'h20B, '0, 1'b1, 1'b0);
        addRow(CmdRead,   12'hF00, '0, 1'b1, 1'b0);
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================
    initial begin
        int  i;
        int  errorsBefore;
        rowT r;
        rst         = 1'b1;
        cmdValid    = 1'b0;
        cmd         = CmdRead;
        addr        = '0;
        fillData    = '0;
        outReady    = 1'b0;
        errorCount  = 0;
        failedTests = 0;
        noiseState  = 8'h03;
        refRng      = `POSMAP_RNG_SEED;
        for (i = 0; i < onChipEntries; i++) refOnChipSet[i] = 1'b0;
        for (i = 0; i < numLines; i++) refLineValid[i] = 1'b0;
        buildTable();
        repeat (10) @(negedge Clock);
        rst = 1'b0;
        for (i = 0; i < rows.size(); i++) begin
            r            = rows[i];
            errorsBefore = errorCount;
            applyRow(r);
            if (errorCount != errorsBefore) failedTests++;
            $display("Test %0d %s addr %h: %s", i, r.cmd.name(), r.addr,
                     (errorCount != errorsBefore) ? "failed" : "ok");
        end
        $display("Tests run %0d, failed %0d, mismatches %0d", rows.size(), failedTests,
                 errorCount);
        if (errorCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        wait (rst === 1'b0);
        repeat (rows.size() * 50) @(posedge Clock);
        $display("Timeout: the command table did not finish within %0d cycles",
                 rows.size() * 50);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/posMapPlb_assertions.sv */
`default_nettype none

module posMapPlbAssertions (
    input logic                 Clock,
    input logic                 rst,
    input logic                 cmdValid,
    input logic                 cmdReady,
    input logic                 outReady,
    input logic                 valid,
    input logic                 hit,
    input posMapPkg::leafT      oldLeaf,
    input posMapPkg::leafT      newLeaf,
    input logic                 evict,
    input posMapPkg::addrT      evictAddr,
    input posMapPkg::leafBlockT evictData
);

    // ======================================================================
    // Output handshake
    // ======================================================================
    resultHeld: assert property (@(posedge Clock) disable iff (rst)
        (valid && !outReady) |=> (valid && $stable(hit) && $stable(oldLeaf)
            && $stable(newLeaf) && $stable(evict) && $stable(evictAddr)
            && $stable(evictData)))
        else $error("Result outputs changed while outReady was low");

    // No new command from acceptance until the result has been taken
    readyBlocked: assert property (@(posedge Clock) disable iff (rst)
        (valid || $past(cmdValid && cmdReady) || $past(cmdValid && cmdReady, 2))
            |-> !cmdReady)
        else $error("cmdReady high while a command was in flight or a result pending");

    // Accept edge, RAM read edge, then the result register edge
    validAfterAccept: assert property (@(posedge Clock) disable iff (rst)
        $past(cmdValid && cmdReady, 3) |-> $rose(valid))
        else $error("valid did not rise two edges after acceptance");

    validFromAccept: assert property (@(posedge Clock) disable iff (rst)
        $rose(valid) |-> $past(cmdValid && cmdReady, 3))
        else $error("valid rose without an acceptance two edges earlier");

endmodule

bind posMapPlb posMapPlbAssertions u_checks (
    .Clock     (Clock),
    .rst       (rst),
    .cmdValid  (cmdValid),
    .cmdReady  (cmdReady),
    .outReady  (outReady),
    .valid     (valid),
    .hit       (hit),
    .oldLeaf   (oldLeaf),
    .newLeaf   (newLeaf),
    .evict     (evict),
    .evictAddr (evictAddr),
    .evictData (evictData)
);

`default_nettype wire

/* verilog/posMapPlb.sv */
`default_nettype none

`include "posMap_cfg.svh"

module posMapPlb (
    input  logic                 Clock,
    input  logic                 rst,
    output logic                 cmdReady,
    input  logic                 cmdValid,
    input  posMapPkg::cacheCmdT  cmd,
    input  posMapPkg::addrT      addr,
    input  posMapPkg::leafBlockT fillData,
    input  logic                 outReady,
    output logic                 valid,
    output logic                 hit,
    output posMapPkg::leafT      oldLeaf,
    output posMapPkg::leafT      newLeaf,
    output logic                 evict,
    output posMapPkg::addrT      evictAddr,
    output posMapPkg::leafBlockT evictData
);

    import posMapPkg::*;

    localparam int onChipEntries = 1 << `POSMAP_LOG_ONCHIP;

    logic                          accept;
    logic                          startQ;
    logic                          inFlight;
    logic                          onChipR;
    logic                          onChipDone;
    logic                          wrPend;
    logic                          done;
    logic                          advance;
    cacheCmdT                      cmdR;
    addrT                          addrR;
    leafBlockT                     fillR;
    logic [onChipEntries-1:0]      setBits;
    logic                          mapEnable;
    logic [`POSMAP_LOG_ONCHIP-1:0] mapIndex;
    leafT                          mapRd;
    leafT                          rngLeaf;
    logic                          cacheLookup;
    logic                          cacheDone;
    logic                          cacheHit;
    logic                          cacheEvict;
    logic                          cacheBusy;
    leafT                          cacheLeaf;
    addrT                          cacheEvictAddr;
    leafBlockT                     cacheEvictData;

    // ======================================================================
    // Command acceptance
    // ======================================================================
    assign cmdReady = !valid && !inFlight && !wrPend && !cacheBusy;
    assign accept   = cmdValid && cmdReady;
    assign done     = onChipDone || cacheDone;

    always_ff @(posedge Clock) begin
        if (rst) begin
            startQ     <= 1'b0;
            onChipDone <= 1'b0;
            inFlight   <= 1'b0;
        end else begin
            startQ     <= accept;
            onChipDone <= startQ && onChipR;   // Map read has landed
            if (accept)    inFlight <= 1'b1;
            else if (done) inFlight <= 1'b0;
        end
    end

    always_ff @(posedge Clock) begin
        if (accept) begin
            cmdR    <= cmd;
            addrR   <= addr;
            fillR   <= fillData;
            onChipR <= (addr >= `POSMAP_ONCHIP_START);
        end
    end

    // ======================================================================
    // On-chip map, read then write back on update
    // ======================================================================
    assign mapIndex  = addrR[`POSMAP_LOG_ONCHIP-1:0];
    assign wrPend    = onChipDone && (cmdR == CmdUpdate);
    assign mapEnable = (startQ && onChipR) || wrPend;

    always_ff @(posedge Clock) begin
        if (rst) setBits <= '0;
        else if (wrPend) setBits[mapIndex] <= 1'b1;
    end

    syncRam #(.dataT(leafT), .logDepth(`POSMAP_LOG_ONCHIP)) onChipMap (
        .Clock  (Clock),
        .rst    (rst),
        .enable (mapEnable),
        .write  (wrPend),
        .index  (mapIndex),
        .wrData (rngLeaf),
        .rdData (mapRd)
    );

    // Leaf cache for everything below the boundary
    assign cacheLookup = startQ && !onChipR;

    leafCache plb (
        .Clock      (Clock),
        .rst        (rst),
        .lookup     (cacheLookup),
        .cmd        (cmdR),
        .addr       (addrR),
        .fillData   (fillR),   // Held in fillR until the next acceptance
        .newLeaf    (rngLeaf),
        .lookupDone (cacheDone),
        .hit        (cacheHit),
        .leaf       (cacheLeaf),
        .evict      (cacheEvict),
        .evictAddr  (cacheEvictAddr),
        .evictData  (cacheEvictData),
        .busy       (cacheBusy)
    );

    // Consume a leaf only when an update actually stores it
    assign advance = wrPend || (cacheDone && cacheHit && (cmdR == CmdUpdate));

    leafRng rng (
        .Clock   (Clock),
        .rst     (rst),
        .advance (advance),
        .newLeaf (rngLeaf)
    );

    // ======================================================================
    // Result registers, held until outReady
    // ======================================================================
    always_ff @(posedge Clock) begin
        if (rst) begin
            valid <= 1'b0;
            evict <= 1'b0;
        end else if (valid && outReady) begin
            valid <= 1'b0;
            evict <= 1'b0;
        end else if (done) begin
            valid <= 1'b1;
            evict <= cacheEvict;
        end
    end

    always_ff @(posedge Clock) begin
        if (done) begin
            hit <= onChipDone || cacheHit;
            if (onChipDone)
                oldLeaf <= setBits[mapIndex] ? mapRd : '0;   // Unset entry reads as 0
            else
                oldLeaf <= (cmdR == CmdRefill) ? '0 : cacheLeaf;
            // Refill reports the stored slot, never a fresh leaf
            newLeaf   <= (!onChipDone && cmdR == CmdRefill) ? cacheLeaf : rngLeaf;
            evictAddr <= cacheEvict ? cacheEvictAddr : '0;
            evictData <= cacheEvict ? cacheEvictData : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/leafCache.sv */
`default_nettype none

`include "posMap_cfg.svh"

module leafCache (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 lookup,
    input  posMapPkg::cacheCmdT  cmd,
    input  posMapPkg::addrT      addr,
    input  posMapPkg::leafBlockT fillData,
    input  posMapPkg::leafT      newLeaf,
    output logic                 lookupDone,
    output logic                 hit,
    output posMapPkg::leafT      leaf,
    output logic                 evict,
    output posMapPkg::addrT      evictAddr,
    output posMapPkg::leafBlockT evictData,
    output logic                 busy
);

    import posMapPkg::*;

    localparam int offW  = `POSMAP_LOG_LEAVES;
    localparam int idxW  = `POSMAP_LOG_LINES;
    localparam int tagLo = offW + idxW;

    logic [(1 << idxW)-1:0]   lineValid;
    cacheCmdT                 cmdQ;
    logic [offW-1:0]          offQ;
    logic [idxW-1:0]          idxQ;
    logic [`POSMAP_TAG_W-1:0] tagQ;
    logic [idxW-1:0]          ramIdx;
    leafBlockT                dataRd;
    leafBlockT                blockWr;
    tagEntryT                 tagRd;
    tagEntryT                 tagWr;
    logic                     tagMatch;
    logic                     lineHit;
    logic                     isRefill;
    logic                     isUpdate;
    logic                     dataWrite;
    logic                     tagWrite;

    // ======================================================================
    // Lookup stage
    // ======================================================================
    always_ff @(posedge Clock) begin
        if (rst) lookupDone <= 1'b0;
        else     lookupDone <= lookup;
    end

    always_ff @(posedge Clock) begin
        if (lookup) begin
            cmdQ <= cmd;
            offQ <= addr[offW-1:0];
            idxQ <= addr[tagLo-1:offW];
            tagQ <= addr[`POSMAP_ADDR_W-1:tagLo];
        end
    end

    // Index comes straight from the address on lookup, from the saved copy on write
    assign ramIdx = lookup ? addr[tagLo-1:offW] : idxQ;

    // ======================================================================
    // Compare and answer, valid while lookupDone is high
    // ======================================================================
    assign isRefill = (cmdQ == CmdRefill);
    assign isUpdate = (cmdQ == CmdUpdate);
    assign tagMatch = (tagRd.tag == tagQ);
    assign lineHit  = lineValid[idxQ] && tagMatch;

    assign hit   = lookupDone && lineHit && !isRefill;
    assign evict = lookupDone && isRefill && lineValid[idxQ] && !tagMatch;

    // A refill reports the leaf of its own slot from the incoming block
    assign leaf = isRefill ? fillData[offQ] : (lineHit ? dataRd[offQ] : '0);

    assign evictAddr = {tagRd.tag, idxQ, {offW{1'b0}}};
    assign evictData = dataRd;

    // ======================================================================
    // Write back on the edge that closes the answer cycle
    // ======================================================================
    assign dataWrite = lookupDone && (isRefill || (isUpdate && lineHit));
    assign tagWrite  = lookupDone && isRefill;
    assign busy      = dataWrite;

    always_comb begin
        blockWr = dataRd;
        if (isRefill) begin
            blockWr = fillData;
        end else begin
            blockWr[offQ] = newLeaf;   // Only the addressed slot changes
        end
    end

    assign tagWr = '{tag: tagQ};

    always_ff @(posedge Clock) begin
        if (rst) begin
            lineValid <= '0;
        end else if (tagWrite) begin
            lineValid[idxQ] <= 1'b1;
        end
    end

    syncRam #(.dataT(leafBlockT), .logDepth(idxW)) dataRam (
        .Clock  (Clock),
        .rst    (rst),
        .enable (lookup || dataWrite),
        .write  (dataWrite),
        .index  (ramIdx),
        .wrData (blockWr),
        .rdData (dataRd)
    );

    syncRam #(.dataT(tagEntryT), .logDepth(idxW)) tagRam (
        .Clock  (Clock),
        .rst    (rst),
        .enable (lookup || tagWrite),
        .write  (tagWrite),
        .index  (ramIdx),
        .wrData (tagWr),
        .rdData (tagRd)
    );

endmodule

`default_nettype wire

/* verilog/leafRng.sv */
`default_nettype none

`include "posMap_cfg.svh"

module leafRng (
    input  logic            Clock,
    input  logic            rst,
    input  logic            advance,
    output posMapPkg::leafT newLeaf
);

    logic [15:0] state;
    logic [15:0] nextState;

    // Galois form, shift right and fold taps in on a dropped one
    assign nextState = (state >> 1) ^ (state[0] ? 16'(`POSMAP_RNG_TAPS) : 16'h0000);

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= `POSMAP_RNG_SEED;
        end else if (advance) begin
            state <= nextState;   // One step per consumed leaf
        end
    end

    assign newLeaf = state[`POSMAP_LEAF_W-1:0];

endmodule

`default_nettype wire

/* verilog/syncRam.sv */
`default_nettype none

module syncRam #(
    parameter type dataT    = logic [7:0],
    parameter int  logDepth = 4
) (
    input  logic                Clock,
    input  logic                rst,
    input  logic                enable,
    input  logic                write,
    input  logic [logDepth-1:0] index,
    input  dataT                wrData,
    output dataT                rdData
);

    dataT mem [0:(1 << logDepth)-1];

    // Contents are never cleared, callers keep their own valid bits
    always_ff @(posedge Clock) begin
        if (enable && write) mem[index] <= wrData;
    end

    // Read port register, one edge of latency
    always_ff @(posedge Clock) begin
        if (rst) begin
            rdData <= '0;
        end else if (enable && !write) begin
            rdData <= mem[index];
        end
    end

endmodule

`default_nettype wire

/* verilog/posMapPkg.sv */
`default_nettype none

`include "posMap_cfg.svh"

package posMapPkg;

    // Command encoding seen by the controller
    typedef enum logic [1:0] {
        CmdUpdate = 2'd0,   // Return old leaf, remap to a new one
        CmdRead   = 2'd1,   // Return leaf only
        CmdRefill = 2'd2    // Install a whole block
    } cacheCmdT;

    typedef logic [`POSMAP_LEAF_W-1:0] leafT;

    typedef logic [`POSMAP_ADDR_W-1:0] addrT;

    // Slot k holds the leaf of block base + k
    typedef leafT [(1 << `POSMAP_LOG_LEAVES)-1:0] leafBlockT;

    // Address bits above the line index and slot offset
    typedef struct packed {
        logic [`POSMAP_TAG_W-1:0] tag;
    } tagEntryT;

endpackage

`default_nettype wire

/* include/posMap_cfg.svh */
`ifndef POSMAP_CFG_SVH
`define POSMAP_CFG_SVH

// Program address and leaf label widths
`define POSMAP_ADDR_W       12
`define POSMAP_LEAF_W       10

// Leaf cache geometry
`define POSMAP_LOG_LEAVES   2   // Four leaves per block
`define POSMAP_LOG_LINES    4   // Sixteen direct-mapped lines
`define POSMAP_TAG_W        (`POSMAP_ADDR_W - `POSMAP_LOG_LINES - `POSMAP_LOG_LEAVES)

// On-chip map covers the top of the address space,
// indexed by the low address bits
`define POSMAP_ONCHIP_START 12'hF00
`define POSMAP_LOG_ONCHIP   8

// Leaf generator
`define POSMAP_RNG_SEED     16'h02A5
`define POSMAP_RNG_TAPS     16'hB400

`endif
